// File: hdl/rp_macros.svh
// width, region decode and housekeeping register map constants
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

// data widths
`define RP_ADC_W        14            // converter sample width
`define RP_BUS_W        32            // system bus address and data

// region decoding, addr[22:20] picks one of eight slaves
`define RP_REGIONS      8
`define RP_REGION_LSB   20
`define RP_REGION_MSB   22
`define RP_HK_REGION    0             // housekeeping lives in region 0

// housekeeping map, byte offsets inside the region
`define RP_HK_ID        32'h5250_4b01 // read-only id word
`define RP_OFS_ID       20'h00000
`define RP_OFS_CTRL     20'h00004     // bit 0 is the digital loop
`define RP_OFS_LED      20'h00008
`define RP_OFS_DAC_A    20'h00010
`define RP_OFS_DAC_B    20'h00014
`define RP_OFS_ADC_A    20'h00020     // read only
`define RP_OFS_ADC_B    20'h00024     // read only

`endif

// File: hdl/rp_bus_pkg.sv
// system bus request and response struct types
`default_nettype none

`include "rp_macros.svh"

package rp_bus_pkg;

  // master to slave, wen/ren are single-cycle strobes
  typedef struct packed {
    logic [`RP_BUS_W-1:0] addr;   // byte address, region in 22:20
    logic [`RP_BUS_W-1:0] wdata;  // full word, no byte select
    logic                 wen;    // write strobe
    logic                 ren;    // read strobe
  } sys_req_t;

  // slave to master, everything valid while ack is high
  typedef struct packed {
    logic [`RP_BUS_W-1:0] rdata;
    logic                 err;    // bad offset or write to read-only word
    logic                 ack;    // one cycle per request
  } sys_rsp_t;

endpackage

`default_nettype wire

// File: hdl/rp_analog_pkg.sv
// sample, converter code and channel pair struct types
`default_nettype none

`include "rp_macros.svh"

package rp_analog_pkg;

  typedef logic signed [`RP_ADC_W-1:0] sample_t;  // two's complement
  typedef logic        [`RP_ADC_W-1:0] code_t;    // neg-slope offset binary

  typedef struct packed {
    sample_t a;  // channel 1
    sample_t b;  // channel 2
  } sample_pair_t;

  typedef struct packed {
    code_t a;
    code_t b;
  } code_pair_t;

endpackage

`default_nettype wire

// File: hdl/rp_sys_decoder.sv
// system bus region decoder, strobe masking and response multiplexer
`timescale 1ns/100ps
`default_nettype none

`include "rp_macros.svh"

module rp_sys_decoder (
  input  wire                  adc_clk,
  input  wire                  rst_i,
  input  wire rp_bus_pkg::sys_req_t sys_req_i,  // from the processor side
  output rp_bus_pkg::sys_rsp_t sys_rsp_o,
  output rp_bus_pkg::sys_req_t hk_req_o,        // region 0 slave
  input  wire rp_bus_pkg::sys_rsp_t hk_rsp_i
);

  import rp_bus_pkg::*;

  logic                                        strobe;
  logic [`RP_REGION_MSB-`RP_REGION_LSB:0]      addr_region;  // region of this request
  logic [`RP_REGION_MSB-`RP_REGION_LSB:0]      region_q;     // region of last request
  logic [`RP_REGION_MSB-`RP_REGION_LSB:0]      rsp_region;
  logic [`RP_REGIONS-1:0]                      cs;           // one-hot select
  sys_rsp_t                                    region_rsp [`RP_REGIONS];

  assign strobe      = sys_req_i.wen | sys_req_i.ren;
  assign addr_region = sys_req_i.addr[`RP_REGION_MSB:`RP_REGION_LSB];

  // addr is only valid with the strobe, so remember where a delayed ack comes from
  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      region_q <= '0;
    else if (strobe)
      region_q <= addr_region;
  end

  assign rsp_region = strobe ? addr_region : region_q;
  assign cs         = {{(`RP_REGIONS-1){1'b0}}, 1'b1} << rsp_region;

  // housekeeping sees only its own strobes
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & cs[`RP_HK_REGION];
    hk_req_o.ren = sys_req_i.ren & cs[`RP_HK_REGION];
  end

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int r = 0; r < `RP_REGIONS; r++)
      region_rsp[r] = '{rdata: '0, err: 1'b0, ack: strobe};  // empty slot, ack at once
    region_rsp[`RP_HK_REGION] = hk_rsp_i;
  end

  always_comb
  begin
    sys_rsp_o = '0;
    for (int r = 0; r < `RP_REGIONS; r++)
      if (cs[r])
        sys_rsp_o = region_rsp[r];  // only one bit set
  end

endmodule

`default_nettype wire

// File: hdl/rp_hk_regs.sv
// housekeeping registers: id, loop control, leds, static dac words, adc readback
`timescale 1ns/100ps
`default_nettype none

`include "rp_macros.svh"

module rp_hk_regs (
  input  wire                               adc_clk,
  input  wire                               rst_i,
  input  wire rp_bus_pkg::sys_req_t         req_i,   // strobes already region masked
  output rp_bus_pkg::sys_rsp_t              rsp_o,
  input  wire rp_analog_pkg::sample_pair_t  adc_i,   // converted samples
  output rp_analog_pkg::sample_pair_t       dac_o,   // static dac words
  output logic                              loop_o,  // digital loop switch
  output logic [7:0]                        led_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  logic [`RP_REGION_LSB-1:0] off;      // offset inside the region
  logic [`RP_BUS_W-1:0]      rd_dat;
  logic                      map_hit;  // offset exists
  logic                      wr_ok;    // offset is writable
  logic                      loop_q;
  logic [7:0]                led_q;
  sample_pair_t              dac_q;
  sample_pair_t              adc_q;    // readback copy
  sys_rsp_t                  rsp_q;

  assign off = req_i.addr[`RP_REGION_LSB-1:0];

  ////////////////////////////////////////////////////////////
  // offset decode and read mux
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_dat  = '0;
    map_hit = 1'b1;
    wr_ok   = 1'b0;
    case (off)
      `RP_OFS_ID:    rd_dat = `RP_HK_ID;
      `RP_OFS_CTRL:
      begin
        rd_dat = {{(`RP_BUS_W-1){1'b0}}, loop_q};
        wr_ok  = 1'b1;
      end
      `RP_OFS_LED:
      begin
        rd_dat = {{(`RP_BUS_W-8){1'b0}}, led_q};
        wr_ok  = 1'b1;
      end
      `RP_OFS_DAC_A:
      begin
        rd_dat = {{(`RP_BUS_W-`RP_ADC_W){dac_q.a[`RP_ADC_W-1]}}, dac_q.a};  // sign extend
        wr_ok  = 1'b1;
      end
      `RP_OFS_DAC_B:
      begin
        rd_dat = {{(`RP_BUS_W-`RP_ADC_W){dac_q.b[`RP_ADC_W-1]}}, dac_q.b};
        wr_ok  = 1'b1;
      end
      `RP_OFS_ADC_A: rd_dat = {{(`RP_BUS_W-`RP_ADC_W){adc_q.a[`RP_ADC_W-1]}}, adc_q.a};
      `RP_OFS_ADC_B: rd_dat = {{(`RP_BUS_W-`RP_ADC_W){adc_q.b[`RP_ADC_W-1]}}, adc_q.b};
      default:       map_hit = 1'b0;  // hole in the map, reads as 0
    endcase
  end

  ////////////////////////////////////////////////////////////
  // writable registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
      dac_q  <= '0;
    end
    else if (req_i.wen)
    begin
      case (off)
        `RP_OFS_CTRL:  loop_q  <= req_i.wdata[0];
        `RP_OFS_LED:   led_q   <= req_i.wdata[7:0];
        `RP_OFS_DAC_A: dac_q.a <= req_i.wdata[`RP_ADC_W-1:0];  // low bits only
        `RP_OFS_DAC_B: dac_q.b <= req_i.wdata[`RP_ADC_W-1:0];
        default:       ;                                      // read-only or unmapped
      endcase
    end
  end

  // latest sample, refreshed every cycle
  always_ff @(posedge adc_clk)
  begin
    adc_q <= adc_i;
  end

  // response one cycle after the strobe
  always_ff @(posedge adc_clk)
  begin
    rsp_q.rdata <= req_i.ren ? rd_dat : '0;
    rsp_q.err   <= ~map_hit | (req_i.wen & ~wr_ok);
    if (rst_i)
      rsp_q.ack <= 1'b0;
    else
      rsp_q.ack <= req_i.wen | req_i.ren;
  end

  assign rsp_o  = rsp_q;
  assign dac_o  = dac_q;
  assign loop_o = loop_q;
  assign led_o  = led_q;

endmodule

`default_nettype wire

// File: hdl/rp_adc_frontend.sv
// adc input register, offset binary to two's complement, digital loop select
`timescale 1ns/100ps
`default_nettype none

`include "rp_macros.svh"

module rp_adc_frontend (
  input  wire                               adc_clk,
  input  wire                               rst_i,
  input  wire rp_analog_pkg::code_t         adc_dat_a_i,  // raw pins ch1
  input  wire rp_analog_pkg::code_t         adc_dat_b_i,  // raw pins ch2
  input  wire                               loop_i,       // take dac words instead
  input  wire rp_analog_pkg::sample_pair_t  dac_i,
  output rp_analog_pkg::sample_pair_t       adc_o
);

  import rp_analog_pkg::*;

  localparam code_t MID_CODE = {1'b0, {(`RP_ADC_W-1){1'b1}}};  // converts to 0

  code_pair_t   raw_q;  // io register
  sample_pair_t conv;

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      raw_q <= '{a: MID_CODE, b: MID_CODE};
    else
      raw_q <= '{a: adc_dat_a_i, b: adc_dat_b_i};
  end

  // negative slope, keep msb and flip the rest
  assign conv.a = {raw_q.a[`RP_ADC_W-1], ~raw_q.a[`RP_ADC_W-2:0]};
  assign conv.b = {raw_q.b[`RP_ADC_W-1], ~raw_q.b[`RP_ADC_W-2:0]};

  assign adc_o = loop_i ? dac_i : conv;  // digital loopback

endmodule

`default_nettype wire

// File: hdl/rp_dac_backend.sv
// dac two's complement to offset binary, output register and dac reset
`timescale 1ns/100ps
`default_nettype none

`include "rp_macros.svh"

module rp_dac_backend (
  input  wire                               adc_clk,
  input  wire                               rst_i,
  input  wire rp_analog_pkg::sample_pair_t  dac_i,     // signed words
  output rp_analog_pkg::code_pair_t         dac_o,     // to the pins
  output logic                              dac_rst_o
);

  import rp_analog_pkg::*;

  code_pair_t dac_q;
  logic       dac_rst_q;

  ////////////////////////////////////////////////////////////
  // output register, same flip rule as the adc side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (rst_i)
      dac_q <= '0;  // pins quiet during reset
    else
    begin
      dac_q.a <= {dac_i.a[`RP_ADC_W-1], ~dac_i.a[`RP_ADC_W-2:0]};
      dac_q.b <= {dac_i.b[`RP_ADC_W-1], ~dac_i.b[`RP_ADC_W-2:0]};
    end
  end

  // converter reset, one register behind the system reset
  always_ff @(posedge adc_clk)
  begin
    dac_rst_q <= rst_i;
  end

  assign dac_o     = dac_q;
  assign dac_rst_o = dac_rst_q;

endmodule

`default_nettype wire

// File: hdl/rp_top.sv
// top level: bus decoder, housekeeping, adc front end and dac back end
`timescale 1ns/100ps
`default_nettype none

module rp_top (
  input  wire                         adc_clk,
  input  wire                         rst_i,
  // adc pins
  input  wire rp_analog_pkg::code_t   adc_dat_a_i,
  input  wire rp_analog_pkg::code_t   adc_dat_b_i,
  // system bus
  input  wire rp_bus_pkg::sys_req_t   sys_req_i,
  output rp_bus_pkg::sys_rsp_t        sys_rsp_o,
  // dac pins, two parallel words
  output rp_analog_pkg::code_t        dac_dat_a_o,
  output rp_analog_pkg::code_t        dac_dat_b_o,
  output logic                        dac_rst_o,
  output logic [7:0]                  led_o
);

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  sys_req_t     hk_req;     // region 0 request
  sys_rsp_t     hk_rsp;
  sample_pair_t dac_words;  // from the register block
  sample_pair_t adc_smp;    // converted or looped back
  code_pair_t   dac_codes;
  logic         loop;

  ////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////

  rp_sys_decoder i_dec (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp)
  );

  rp_hk_regs i_hk (
    .adc_clk (adc_clk),
    .rst_i   (rst_i),
    .req_i   (hk_req),
    .rsp_o   (hk_rsp),
    .adc_i   (adc_smp),
    .dac_o   (dac_words),
    .loop_o  (loop),
    .led_o   (led_o)
  );

  ////////////////////////////////////////////////////////////
  // analog side
  ////////////////////////////////////////////////////////////

  rp_adc_frontend i_adc (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_i      (loop),
    .dac_i       (dac_words),  // loopback path
    .adc_o       (adc_smp)
  );

  rp_dac_backend i_dac (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .dac_i     (dac_words),
    .dac_o     (dac_codes),
    .dac_rst_o (dac_rst_o)
  );

  assign dac_dat_a_o = dac_codes.a;
  assign dac_dat_b_o = dac_codes.b;

endmodule

`default_nettype wire

// File: verification/rp_tb_clkgen.sv
// free running testbench clock source
`timescale 1ns/100ps
`default_nettype none

module rp_tb_clkgen #(
  parameter int PERIOD_NS = 8  // full period
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;  // first rising edge half a period in
    forever
      #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: verification/rp_assertions.sv
// system bus handshake assertions and their bind into the region decoder
`timescale 1ns/100ps
`default_nettype none

module rp_assertions (
  input wire                        adc_clk,
  input wire                        rst_i,
  input wire rp_bus_pkg::sys_req_t  req_i,  // master side request
  input wire rp_bus_pkg::sys_rsp_t  rsp_i   // merged response
);

  logic strobe;

  assign strobe = req_i.wen | req_i.ren;

  ////////////////////////////////////////////////////////////
  // handshake rules
  ////////////////////////////////////////////////////////////

  // one ack per request, never stretched
  ack_one_cycle: assert property (@(posedge adc_clk) disable iff (rst_i)
    rsp_i.ack |=> !rsp_i.ack)
    else $error("ack held high for two cycles in a row");

  // empty regions answer at once, housekeeping one cycle later
  ack_in_time: assert property (@(posedge adc_clk) disable iff (rst_i)
    (strobe && !rsp_i.ack) |=> rsp_i.ack)
    else $error("request not acknowledged within one cycle");

  no_dual_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(req_i.wen && req_i.ren))
    else $error("write and read strobes high together");

endmodule

// watch the processor side port of every decoder
bind rp_sys_decoder rp_assertions i_bus_assert (
  .adc_clk (adc_clk),
  .rst_i   (rst_i),
  .req_i   (sys_req_i),
  .rsp_i   (sys_rsp_o)
);

`default_nettype wire

// File: verification/rp_tb.sv
// testbench for rp_top: stimulus, reference model, response compare and watchdog
`timescale 1ns/100ps
`default_nettype none

`include "rp_macros.svh"

module rp_tb;

  import rp_bus_pkg::*;
  import rp_analog_pkg::*;

  localparam int CLK_NS     = 8;
  localparam int DRV_NS     = 1;   // input skew after the rising edge
  localparam int N_DAC      = 8;   // rounds per test group
  localparam int N_ADC      = 8;
  localparam int N_LOOP     = 4;
  localparam int N_LED      = 4;
  localparam int N_TRANS    = 1 + 4 * N_DAC + 2 * N_ADC + 3 + 4 * N_LOOP
                              + 2 * (`RP_REGIONS - 1) + 7 + 2 * N_LED;
  localparam int TIMEOUT_NS = (N_TRANS * 10 + 100) * CLK_NS;
  localparam logic [31:0] LFSR_SEED = 32'h9fc7291e;
  localparam logic [`RP_ADC_W-1:0] LOW_MASK = {1'b0, {(`RP_ADC_W-1){1'b1}}};

  logic         adc_clk;
  logic         rst;
  sys_req_t     sys_req;
  sys_rsp_t     sys_rsp;
  code_t        pin_a;       // raw adc pins
  code_t        pin_b;
  code_t        dac_a_pin;
  code_t        dac_b_pin;
  logic         dac_rst;
  logic [7:0]   led;

  // reference model state
  logic         m_loop;
  logic [7:0]   m_led;
  sample_t      m_dac_a;
  sample_t      m_dac_b;

  logic [31:0]  lfsr;
  sys_rsp_t     exp_q[$];    // one entry per outstanding request
  int           acks_seen;

  rp_tb_clkgen #(.PERIOD_NS(CLK_NS)) i_clk (.clk_o(adc_clk));

  rp_top uut (
    .adc_clk     (adc_clk),
    .rst_i       (rst),
    .adc_dat_a_i (pin_a),
    .adc_dat_b_i (pin_b),
    .sys_req_i   (sys_req),
    .sys_rsp_o   (sys_rsp),
    .dac_dat_a_o (dac_a_pin),
    .dac_dat_b_o (dac_b_pin),
    .dac_rst_o   (dac_rst),
    .led_o       (led)
  );

  ////////////////////////////////////////////////////////////
  // random numbers, x^32 + x^22 + x^2 + x + 1
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      r    = {r[30:0], lfsr[0]};  // one step per bit
    end
    return r;
  endfunction

  function automatic code_t rand_code();
    logic [31:0] r;
    r = rand_bits(`RP_ADC_W);
    return r[`RP_ADC_W-1:0];
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // sign bit stays, the other 13 bits flip, same both ways
  function automatic logic [`RP_ADC_W-1:0] flip_low(input logic [`RP_ADC_W-1:0] v);
    return v ^ LOW_MASK;
  endfunction

  function automatic code_t dac_code(input sample_t s);
    return flip_low(s);
  endfunction

  function automatic sample_t adc_expect(input code_t pin, input sample_t word);
    return m_loop ? word : flip_low(pin);  // loop replaces the pins
  endfunction

  function automatic logic [`RP_BUS_W-1:0] sext(input sample_t v);
    return {{(`RP_BUS_W-`RP_ADC_W){v[`RP_ADC_W-1]}}, v};
  endfunction

  function automatic logic [`RP_BUS_W-1:0] region_addr(input int region,
                                                       input logic [`RP_REGION_LSB-1:0] ofs);
    logic [`RP_BUS_W-1:0] a;
    a = '0;
    a[`RP_REGION_MSB:`RP_REGION_LSB] = region[`RP_REGION_MSB-`RP_REGION_LSB:0];
    a[`RP_REGION_LSB-1:0]            = ofs;
    return a;
  endfunction

  // expected response, writes also update the model
  function automatic sys_rsp_t rp_expect(input logic wr, input logic [`RP_BUS_W-1:0] addr,
                                         input logic [`RP_BUS_W-1:0] wdata);
    sys_rsp_t                  rsp;
    logic [`RP_REGION_LSB-1:0] ofs;
    rsp     = '0;
    rsp.ack = 1'b1;  // empty regions: zero data, no error
    ofs     = addr[`RP_REGION_LSB-1:0];
    if (int'(addr[`RP_REGION_MSB:`RP_REGION_LSB]) == `RP_HK_REGION)
    begin
      case (ofs)
        `RP_OFS_ID:
          if (wr)
            rsp.err = 1'b1;
          else
            rsp.rdata = `RP_HK_ID;
        `RP_OFS_CTRL:
          if (wr)
            m_loop = wdata[0];
          else
            rsp.rdata = {{(`RP_BUS_W-1){1'b0}}, m_loop};
        `RP_OFS_LED:
          if (wr)
            m_led = wdata[7:0];
          else
            rsp.rdata = {{(`RP_BUS_W-8){1'b0}}, m_led};
        `RP_OFS_DAC_A:
          if (wr)
            m_dac_a = wdata[`RP_ADC_W-1:0];  // upper bits dropped
          else
            rsp.rdata = sext(m_dac_a);
        `RP_OFS_DAC_B:
          if (wr)
            m_dac_b = wdata[`RP_ADC_W-1:0];
          else
            rsp.rdata = sext(m_dac_b);
        `RP_OFS_ADC_A:
          if (wr)
            rsp.err = 1'b1;
          else
            rsp.rdata = sext(adc_expect(pin_a, m_dac_a));
        `RP_OFS_ADC_B:
          if (wr)
            rsp.err = 1'b1;
          else
            rsp.rdata = sext(adc_expect(pin_b, m_dac_b));
        default:
          rsp.err = 1'b1;  // hole in the map
      endcase
    end
    return rsp;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and bus driver
  ////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("error: %0t ns, %s mismatch, got %h, expected %h", $time, what, got, exp);
      $display("Test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic check_pins();
    check_value("dac_dat_a_o", 32'(dac_a_pin), 32'(dac_code(m_dac_a)));
    check_value("dac_dat_b_o", 32'(dac_b_pin), 32'(dac_code(m_dac_b)));
  endtask

  task automatic bus_access(input logic wr, input logic [`RP_BUS_W-1:0] addr,
                            input logic [`RP_BUS_W-1:0] wdata);
    int seen;
    seen = acks_seen;
    exp_q.push_back(rp_expect(wr, addr, wdata));
    @(posedge adc_clk);
    #(DRV_NS);
    sys_req.addr  = addr;
    sys_req.wdata = wdata;
    sys_req.wen   = wr;
    sys_req.ren   = ~wr;
    @(posedge adc_clk);
    #(DRV_NS);
    sys_req = '0;               // strobe lasts one cycle
    wait (acks_seen != seen);   // watchdog covers a missing ack
    @(posedge adc_clk);         // idle cycle before the next request
  endtask

  task automatic bus_write(input logic [`RP_BUS_W-1:0] addr, input logic [`RP_BUS_W-1:0] wdata);
    bus_access(1'b1, addr, wdata);
  endtask

  task automatic bus_read(input logic [`RP_BUS_W-1:0] addr);
    bus_access(1'b0, addr, '0);
  endtask

  // new raw codes, then let them reach the readback register
  task automatic set_pins(input code_t a, input code_t b);
    @(posedge adc_clk);
    #(DRV_NS);
    pin_a = a;
    pin_b = b;
    repeat (3) @(posedge adc_clk);
  endtask

  // compare every ack against the oldest expected response
  always @(negedge adc_clk)
  begin : compare_rsp
    sys_rsp_t exp_rsp;
    if (!rst && sys_rsp.ack === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        $display("bus acknowledge at %0t ns with no request outstanding", $time);
        $display("Test failed");
        $fatal(1, "spurious acknowledge");
      end
      else
      begin
        exp_rsp = exp_q.pop_front();
        check_value("rdata", sys_rsp.rdata, exp_rsp.rdata);
        check_value("err", 32'(sys_rsp.err), 32'(exp_rsp.err));
        acks_seen++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test groups
  ////////////////////////////////////////////////////////////

  task automatic dac_roundtrip();
    for (int i = 0; i < N_DAC; i++)
    begin
      bus_write(region_addr(0, `RP_OFS_DAC_A), rand_bits(32));
      bus_write(region_addr(0, `RP_OFS_DAC_B), rand_bits(32));
      @(negedge adc_clk);  // second edge after the last strobe
      check_pins();
      bus_read(region_addr(0, `RP_OFS_DAC_A));
      bus_read(region_addr(0, `RP_OFS_DAC_B));
    end
  endtask

  task automatic adc_readback();
    for (int i = 0; i < N_ADC; i++)
    begin
      set_pins(rand_code(), rand_code());
      bus_read(region_addr(0, `RP_OFS_ADC_A));
      bus_read(region_addr(0, `RP_OFS_ADC_B));
    end
  endtask

  task automatic loopback_readback();
    bus_write(region_addr(0, `RP_OFS_CTRL), 32'h1);
    bus_read(region_addr(0, `RP_OFS_CTRL));
    for (int i = 0; i < N_LOOP; i++)
    begin
      bus_write(region_addr(0, `RP_OFS_DAC_A), rand_bits(32));
      bus_write(region_addr(0, `RP_OFS_DAC_B), rand_bits(32));
      set_pins(rand_code(), rand_code());  // pins must not matter
      bus_read(region_addr(0, `RP_OFS_ADC_A));
      bus_read(region_addr(0, `RP_OFS_ADC_B));
    end
    bus_write(region_addr(0, `RP_OFS_CTRL), 32'h0);
  endtask

  task automatic bad_access();
    for (int r = 1; r < `RP_REGIONS; r++)
    begin
      bus_write(region_addr(r, `RP_OFS_DAC_A), rand_bits(32));  // must not hit housekeeping
      bus_read(region_addr(r, `RP_OFS_ID));
    end
    bus_read(region_addr(0, 20'h0000c));
    bus_write(region_addr(0, 20'h00030), rand_bits(32));
    bus_write(region_addr(0, `RP_OFS_ID), rand_bits(32));
    bus_read(region_addr(0, `RP_OFS_ID));
    bus_write(region_addr(0, `RP_OFS_ADC_A), rand_bits(32));
    bus_read(region_addr(0, `RP_OFS_ADC_A));
    bus_read(region_addr(0, `RP_OFS_DAC_A));
  endtask

  task automatic led_output();
    for (int i = 0; i < N_LED; i++)
    begin
      bus_write(region_addr(0, `RP_OFS_LED), rand_bits(32));
      @(negedge adc_clk);
      check_value("led_o", 32'(led), 32'(m_led));
      bus_read(region_addr(0, `RP_OFS_LED));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin : main
    lfsr      = LFSR_SEED;
    acks_seen = 0;
    m_loop    = 1'b0;  // model starts in the reset state
    m_led     = '0;
    m_dac_a   = '0;
    m_dac_b   = '0;
    rst       = 1'b1;
    sys_req   = '0;
    pin_a     = rand_code();
    pin_b     = rand_code();
    repeat (2) @(posedge adc_clk);
    #(DRV_NS);
    rst = 1'b0;

    // dac reset still held one edge past rst, pins cleared
    @(negedge adc_clk);
    check_value("dac_rst_o", 32'(dac_rst), 32'h1);
    check_value("dac_dat_a_o", 32'(dac_a_pin), 32'h0);
    check_value("dac_dat_b_o", 32'(dac_b_pin), 32'h0);
    check_value("led_o", 32'(led), 32'h0);
    @(negedge adc_clk);
    check_value("dac_rst_o", 32'(dac_rst), 32'h0);
    check_pins();  // now the converted zero words
    bus_read(region_addr(0, `RP_OFS_ID));

    dac_roundtrip();
    adc_readback();
    loopback_readback();
    bad_access();
    led_output();

    if (exp_q.size() != 0)
    begin
      $display("requests left without an acknowledge at the end of the run");
      $display("Test failed");
      $fatal(1, "missing acknowledge");
    end
    else
    begin
      $display("Test completed successfully");
      $finish;
    end
  end

  initial
  begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/rp_bus_pkg.sv
hdl/rp_analog_pkg.sv
hdl/rp_sys_decoder.sv
hdl/rp_hk_regs.sv
hdl/rp_adc_frontend.sv
hdl/rp_dac_backend.sv
hdl/rp_top.sv
verification/rp_tb_clkgen.sv
verification/rp_assertions.sv
verification/rp_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the rp_top testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module rp_tb -o rp_tb_sim
./obj_dir/rp_tb_sim
